//--- src/frame_loop_pkg.sv
// Shared stream beat struct, admission state enum and default port sizes

`default_nettype none

package frame_loop_pkg;

    // Stream geometry
    localparam int DATA_W_DEF = 64;
    localparam int KEEP_W_DEF = DATA_W_DEF / 8;

    // Default per-port sizes, overridable at the top level
    localparam int DEPTH_DEF       = 64;
    localparam int MAX_BEATS_DEF   = 16;
    localparam int LOCK_CYCLES_DEF = 32;

    // One stream beat; user on a last beat flags a bad frame
    typedef struct packed {
        logic [DATA_W_DEF-1:0] data;
        logic [KEEP_W_DEF-1:0] keep;
        logic                  last;
        logic                  user;
    } axis_beat_t;

    // Per-frame admission states
    typedef enum logic [1:0] {
        ADMIT_IDLE  = 2'd0,
        ADMIT_STORE = 2'd1,
        ADMIT_DROP  = 2'd2
    } admit_state_t;

endpackage

`default_nettype wire

//--- src/link_status_timer.sv
// Block lock debounce timer producing a per-port link-up level

`default_nettype none
`timescale 1ns/10ps

module link_status_timer #(
    parameter int LOCK_CYCLES = 32
) (
    input  wire logic clk_125mhz,
    input  wire logic rst_n,
    input  wire logic block_lock,
    output logic      link_up
);

    localparam int CNT_W = (LOCK_CYCLES > 1) ? $clog2(LOCK_CYCLES) : 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(LOCK_CYCLES - 1);

    // Consecutive lock cycles seen so far, minus one once link is up
    logic [CNT_W-1:0] lock_cnt;

    // Link comes up on the edge that samples the LOCK_CYCLES-th lock cycle
    always_ff @(posedge clk_125mhz) begin
        if (!rst_n) begin
            lock_cnt <= '0;
            link_up  <= 1'b0;
        end else if (!block_lock) begin
            // Any loss of lock restarts the count
            lock_cnt <= '0;
            link_up  <= 1'b0;
        end else begin
            if (lock_cnt != CNT_LAST) begin
                lock_cnt <= lock_cnt + 1'b1;
            end
            link_up <= (lock_cnt == CNT_LAST);
        end
    end

endmodule

`default_nettype wire

//--- src/frame_admit_fsm.sv
// Receive frame admission FSM issuing FIFO writes, commits and discards

`default_nettype none
`timescale 1ns/10ps

module frame_admit_fsm
    import frame_loop_pkg::*;
#(
    parameter int MAX_BEATS = 16,
    parameter int DEPTH     = 64
) (
    input  wire logic                       clk_125mhz,
    input  wire logic                       rst_n,
    input  wire logic                       rx_valid,
    input  wire axis_beat_t                 rx_beat,
    input  wire logic                       link_up,
    input  wire logic [$clog2(DEPTH+1)-1:0] free_beats,
    output logic                            wr_en,
    output axis_beat_t                      wr_beat,
    output logic                            commit,
    output logic                            discard
);

    localparam int FREE_W = $clog2(DEPTH + 1);
    localparam int CNT_W  = $clog2(MAX_BEATS + 1);

    admit_state_t     state;
    admit_state_t     state_next;
    logic [CNT_W-1:0] beat_cnt;
    logic [CNT_W-1:0] beat_cnt_next;
    logic             commit_next;
    logic             discard_next;
    logic             admit;
    logic             at_max;

    // Room for a worst-case frame is reserved up front
    assign admit  = link_up && (free_beats >= FREE_W'(MAX_BEATS));
    assign at_max = (beat_cnt == CNT_W'(MAX_BEATS));

    // Beats pass straight to the RAM write port
    assign wr_beat = rx_beat;

    always_comb begin
        state_next    = state;
        beat_cnt_next = beat_cnt;
        wr_en         = 1'b0;
        commit_next   = 1'b0;
        discard_next  = 1'b0;
        if (rx_valid) begin
            case (state)
                ADMIT_IDLE: begin
                    if (admit) begin
                        wr_en = 1'b1;
                        if (rx_beat.last) begin
                            commit_next  = !rx_beat.user;
                            discard_next = rx_beat.user;
                        end else begin
                            state_next    = ADMIT_STORE;
                            beat_cnt_next = CNT_W'(1);
                        end
                    end else if (!rx_beat.last) begin
                        state_next = ADMIT_DROP;
                    end
                end
                ADMIT_STORE: begin
                    if (at_max) begin
                        // Oversize, give back what was written so far
                        discard_next = 1'b1;
                        state_next   = rx_beat.last ? ADMIT_IDLE : ADMIT_DROP;
                    end else begin
                        wr_en         = 1'b1;
                        beat_cnt_next = beat_cnt + 1'b1;
                        if (rx_beat.last) begin
                            commit_next  = !rx_beat.user;
                            discard_next = rx_beat.user;
                            state_next   = ADMIT_IDLE;
                        end
                    end
                end
                ADMIT_DROP: begin
                    if (rx_beat.last) begin
                        state_next = ADMIT_IDLE;
                    end
                end
                default: state_next = ADMIT_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_125mhz) begin
        if (!rst_n) begin
            state    <= ADMIT_IDLE;
            beat_cnt <= '0;
            commit   <= 1'b0;
            discard  <= 1'b0;
        end else begin
            state    <= state_next;
            beat_cnt <= beat_cnt_next;
            commit   <= commit_next;
            discard  <= discard_next;
        end
    end

endmodule

`default_nettype wire

//--- src/frame_fifo_mem.sv
// Frame FIFO RAM with speculative and committed write pointers and registered read

`default_nettype none
`timescale 1ns/10ps

module frame_fifo_mem
    import frame_loop_pkg::*;
#(
    // Power of two
    parameter int DEPTH = 64
) (
    input  wire logic                       clk_125mhz,
    input  wire logic                       rst_n,
    input  wire logic                       wr_en,
    input  wire axis_beat_t                 wr_beat,
    input  wire logic                       commit,
    input  wire logic                       discard,
    input  wire logic                       tx_ready,
    output logic                            tx_valid,
    output axis_beat_t                      tx_beat,
    output logic [$clog2(DEPTH+1)-1:0]      free_beats
);

    localparam int ADDR_W = $clog2(DEPTH);
    localparam int PTR_W  = ADDR_W + 1;
    localparam int FREE_W = $clog2(DEPTH + 1);

    axis_beat_t mem [DEPTH];

    // Pointers carry one wrap bit above the address
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  commit_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [PTR_W-1:0]  used_beats;
    logic [ADDR_W-1:0] wr_addr;
    logic              rd_avail;
    logic              rd_load;

    // A discard in the same cycle as a new first beat rewinds before writing
    assign wr_addr = discard ? commit_ptr[ADDR_W-1:0] : wr_ptr[ADDR_W-1:0];

    // Speculative beats still occupy space
    assign used_beats = wr_ptr - rd_ptr;
    assign free_beats = FREE_W'(DEPTH) - FREE_W'(used_beats);

    // Reader only sees committed frames
    assign rd_avail = (rd_ptr != commit_ptr);
    assign rd_load  = rd_avail && (!tx_valid || tx_ready);

    always_ff @(posedge clk_125mhz) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_beat;
        end
    end

    always_ff @(posedge clk_125mhz) begin
        if (!rst_n) begin
            wr_ptr     <= '0;
            commit_ptr <= '0;
        end else begin
            if (discard) begin
                wr_ptr <= commit_ptr + PTR_W'(wr_en);
            end else if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            // A beat written alongside commit belongs to the next frame
            if (commit) begin
                commit_ptr <= wr_ptr;
            end
        end
    end

    // Output stage holds its beat until the sink takes it
    always_ff @(posedge clk_125mhz) begin
        if (!rst_n) begin
            rd_ptr   <= '0;
            tx_valid <= 1'b0;
        end else if (rd_load) begin
            rd_ptr   <= rd_ptr + 1'b1;
            tx_valid <= 1'b1;
        end else if (tx_ready) begin
            tx_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk_125mhz) begin
        if (rd_load) begin
            tx_beat <= mem[rd_ptr[ADDR_W-1:0]];
        end
    end

endmodule

`default_nettype wire

//--- src/frame_loop_ch.sv
// One loopback port: link timer, admission FSM and frame FIFO

`default_nettype none
`timescale 1ns/10ps

module frame_loop_ch
    import frame_loop_pkg::*;
#(
    parameter int DEPTH       = 64,
    parameter int MAX_BEATS   = 16,
    parameter int LOCK_CYCLES = 32
) (
    input  wire logic       clk_125mhz,
    input  wire logic       rst_n,
    input  wire logic       rx_valid,
    input  wire axis_beat_t rx_beat,
    input  wire logic       rx_block_lock,
    input  wire logic       tx_ready,
    output logic            tx_valid,
    output axis_beat_t      tx_beat,
    output logic            link_up
);

    localparam int FREE_W = $clog2(DEPTH + 1);

    logic              wr_en;
    axis_beat_t        wr_beat;
    logic              commit;
    logic              discard;
    logic [FREE_W-1:0] free_beats;

    link_status_timer #(
        .LOCK_CYCLES(LOCK_CYCLES)
    ) link_status_timer_inst (
        .clk_125mhz(clk_125mhz),
        .rst_n(rst_n),
        .block_lock(rx_block_lock),
        .link_up(link_up)
    );

    frame_admit_fsm #(
        .MAX_BEATS(MAX_BEATS),
        .DEPTH(DEPTH)
    ) frame_admit_fsm_inst (
        .clk_125mhz(clk_125mhz),
        .rst_n(rst_n),
        .rx_valid(rx_valid),
        .rx_beat(rx_beat),
        .link_up(link_up),
        .free_beats(free_beats),
        .wr_en(wr_en),
        .wr_beat(wr_beat),
        .commit(commit),
        .discard(discard)
    );

    frame_fifo_mem #(
        .DEPTH(DEPTH)
    ) frame_fifo_mem_inst (
        .clk_125mhz(clk_125mhz),
        .rst_n(rst_n),
        .wr_en(wr_en),
        .wr_beat(wr_beat),
        .commit(commit),
        .discard(discard),
        .tx_ready(tx_ready),
        .tx_valid(tx_valid),
        .tx_beat(tx_beat),
        .free_beats(free_beats)
    );

endmodule

`default_nettype wire

//--- src/frame_loop_core.sv
// Two-port frame loopback core with per-port link LEDs

`default_nettype none
`timescale 1ns/10ps

module frame_loop_core
    import frame_loop_pkg::*;
#(
    parameter int DEPTH       = DEPTH_DEF,
    parameter int MAX_BEATS   = MAX_BEATS_DEF,
    parameter int LOCK_CYCLES = LOCK_CYCLES_DEF
) (
    input  wire logic       clk_125mhz,
    input  wire logic       rst_n,

    // Receive streams, no back-pressure
    input  wire logic       rx_valid[2],
    input  wire axis_beat_t rx_beat[2],
    input  wire logic       rx_block_lock[2],

    // Transmit streams
    input  wire logic       tx_ready[2],
    output logic            tx_valid[2],
    output axis_beat_t      tx_beat[2],

    output logic [1:0]      sfp_led[2]
);

    logic link_up[2];

    for (genvar n = 0; n < 2; n++) begin : sfp_ch

        frame_loop_ch #(
            .DEPTH(DEPTH),
            .MAX_BEATS(MAX_BEATS),
            .LOCK_CYCLES(LOCK_CYCLES)
        ) frame_loop_ch_inst (
            .clk_125mhz(clk_125mhz),
            .rst_n(rst_n),
            .rx_valid(rx_valid[n]),
            .rx_beat(rx_beat[n]),
            .rx_block_lock(rx_block_lock[n]),
            .tx_ready(tx_ready[n]),
            .tx_valid(tx_valid[n]),
            .tx_beat(tx_beat[n]),
            .link_up(link_up[n])
        );

        // Bit 1 unused on this board
        assign sfp_led[n] = {1'b0, link_up[n]};

    end

endmodule

`default_nettype wire

//--- dv/frame_loop_tb.sv
// Loopback core testbench with clock, reset, random frames, reference model, checks and watchdog

`default_nettype none
`timescale 1ns/10ps

module frame_loop_tb
    import frame_loop_pkg::*;
;

    localparam int DEPTH       = 64;
    localparam int MAX_BEATS   = 16;
    localparam int LOCK_CYCLES = 32;
    localparam int CLK_PERIOD  = 8;
    // Frames per port over all phases at worst case MAX_BEATS+4 beats each
    localparam int N_FRAMES        = 6 + 40 + 30 + 8 + 20;
    localparam int TOTAL_BEATS     = 2 * N_FRAMES * (MAX_BEATS + 4);
    localparam int WATCHDOG_CYCLES = TOTAL_BEATS * 20;

    logic       clk_125mhz = 1'b0;
    logic       rst_n;
    logic       rx_valid[2];
    axis_beat_t rx_beat[2];
    logic       rx_block_lock[2];
    logic       tx_ready[2];
    logic       tx_valid[2];
    axis_beat_t tx_beat[2];
    logic [1:0] sfp_led[2];

    // Reference model state per port
    admit_state_t st[2];
    int           cnt[2];
    int           spec[2];
    int           rdy[2];
    int           pc[2];
    int           pd[2];
    int           lcnt[2];
    bit           ov[2];
    bit           link[2];
    bit           stall[2];
    axis_beat_t   held[2];
    axis_beat_t   cur_q[2][$];
    axis_beat_t   exp_q[2][$];
    int           err_cnt = 0;
    int           checked = 0;

    frame_loop_core #(
        .DEPTH(DEPTH),
        .MAX_BEATS(MAX_BEATS),
        .LOCK_CYCLES(LOCK_CYCLES)
    ) frame_loop_core_inst (
        .clk_125mhz(clk_125mhz),
        .rst_n(rst_n),
        .rx_valid(rx_valid),
        .rx_beat(rx_beat),
        .rx_block_lock(rx_block_lock),
        .tx_ready(tx_ready),
        .tx_valid(tx_valid),
        .tx_beat(tx_beat),
        .sfp_led(sfp_led)
    );

    always #(CLK_PERIOD / 2) clk_125mhz = ~clk_125mhz;

    task automatic reset_model(input int p);
        st[p] = ADMIT_IDLE;
        cnt[p] = 0;
        spec[p] = 0;
        rdy[p] = 0;
        pc[p] = 0;
        pd[p] = 0;
        lcnt[p] = 0;
        ov[p] = 1'b0;
        link[p] = 1'b0;
        stall[p] = 1'b0;
        cur_q[p].delete();
        exp_q[p].delete();
    endtask

    // Frame end decides commit or discard of all beats stored so far
    task automatic close_frame(input int p, input bit bad);
        if (bad) begin
            pd[p] = spec[p];
        end else begin
            pc[p] = spec[p];
            for (int i = 0; i < cur_q[p].size(); i++) begin
                exp_q[p].push_back(cur_q[p][i]);
            end
        end
        cur_q[p].delete();
        spec[p] = 0;
        st[p] = ADMIT_IDLE;
    endtask

    task automatic admit_beat(input int p, input axis_beat_t b, input int free);
        case (st[p])
            ADMIT_IDLE: begin
                // Room for a worst-case frame and only with link up
                if (link[p] && free >= MAX_BEATS) begin
                    cur_q[p].push_back(b);
                    spec[p] = 1;
                    cnt[p] = 1;
                    if (b.last) close_frame(p, b.user);
                    else st[p] = ADMIT_STORE;
                end else if (!b.last) begin
                    st[p] = ADMIT_DROP;
                end
            end
            ADMIT_STORE: begin
                if (cnt[p] == MAX_BEATS) begin
                    // Oversize frame
                    pd[p] = spec[p];
                    spec[p] = 0;
                    cur_q[p].delete();
                    st[p] = b.last ? ADMIT_IDLE : ADMIT_DROP;
                end else begin
                    cur_q[p].push_back(b);
                    spec[p]++;
                    cnt[p]++;
                    if (b.last) close_frame(p, b.user);
                end
            end
            default: if (b.last) st[p] = ADMIT_IDLE;
        endcase
    endtask

    task automatic model_step(input int p);
        int free;
        bit load;
        free = DEPTH - (rdy[p] + pc[p] + pd[p] + spec[p]);
        load = (rdy[p] > 0) && (!ov[p] || tx_ready[p]);
        if (tx_valid[p] !== ov[p]) begin
            $display("error t=%0t tx_valid[%0d] expected=%0b actual=%0b",
                     $time, p, ov[p], tx_valid[p]);
            err_cnt++;
        end
        if (sfp_led[p] !== {1'b0, link[p]}) begin
            $display("error t=%0t sfp_led[%0d] expected=%b actual=%b",
                     $time, p, {1'b0, link[p]}, sfp_led[p]);
            err_cnt++;
        end
        if (stall[p] && tx_beat[p] !== held[p]) begin
            $display("error t=%0t tx_beat[%0d] expected=%h actual=%h (changed under stall)",
                     $time, p, held[p], tx_beat[p]);
            err_cnt++;
        end
        if (tx_valid[p] === 1'b1 && tx_ready[p]) begin
            if (exp_q[p].size() == 0) begin
                $display("Port %0d sent a beat at t=%0t that no kept frame accounts for",
                         p, $time);
                err_cnt++;
            end else begin
                if (tx_beat[p] !== exp_q[p][0]) begin
                    $display("error t=%0t tx_beat[%0d] expected=%h actual=%h",
                             $time, p, exp_q[p][0], tx_beat[p]);
                    err_cnt++;
                end
                exp_q[p].delete(0);
                checked++;
            end
        end
        stall[p] = ov[p] && !tx_ready[p];
        held[p] = tx_beat[p];
        ov[p] = load || stall[p];
        rdy[p] = rdy[p] - int'(load) + pc[p];
        pc[p] = 0;
        pd[p] = 0;
        if (rx_valid[p]) admit_beat(p, rx_beat[p], free);
        lcnt[p] = rx_block_lock[p] ? lcnt[p] + 1 : 0;
        link[p] = (lcnt[p] >= LOCK_CYCLES);
    endtask

    always @(posedge clk_125mhz) begin
        for (int p = 0; p < 2; p++) begin
            if (!rst_n) reset_model(p);
            else model_step(p);
        end
    end

    // Random frames on both ports with tx_ready high at the given percentage
    task automatic run_phase(input int frames, input int pct0, input int pct1);
        int         left[2];
        int         sent[2];
        int         pct[2];
        axis_beat_t b;
        left = '{0, 0};
        sent = '{0, 0};
        pct = '{pct0, pct1};
        while (sent[0] < frames || sent[1] < frames || left[0] > 0 || left[1] > 0) begin
            @(posedge clk_125mhz);
            for (int p = 0; p < 2; p++) begin
                tx_ready[p] <= ($urandom_range(99) < pct[p]);
                if (left[p] == 0 && sent[p] < frames && $urandom_range(3) != 0) begin
                    left[p] = $urandom_range(MAX_BEATS + 4, 1);
                    sent[p]++;
                end
                if (left[p] > 0) begin
                    b.data = {$urandom, $urandom};
                    b.last = (left[p] == 1);
                    b.keep = b.last ? 8'hff >> $urandom_range(7) : 8'hff;
                    b.user = b.last && ($urandom_range(5) == 0);
                    rx_beat[p] <= b;
                    rx_valid[p] <= 1'b1;
                    left[p]--;
                end else begin
                    rx_valid[p] <= 1'b0;
                end
            end
        end
        @(posedge clk_125mhz);
        rx_valid[0] <= 1'b0;
        rx_valid[1] <= 1'b0;
    endtask

    initial begin
        void'($urandom(32'h9545));
        rst_n <= 1'b0;
        for (int p = 0; p < 2; p++) begin
            rx_valid[p] <= 1'b0;
            rx_beat[p] <= '0;
            rx_block_lock[p] <= 1'b0;
            tx_ready[p] <= 1'b0;
        end
        repeat (3) @(posedge clk_125mhz);
        rst_n <= 1'b1;
        @(posedge clk_125mhz);
        rx_block_lock[0] <= 1'b1;
        rx_block_lock[1] <= 1'b1;
        // Early frames meet a link that is still down
        run_phase(6, 100, 100);
        run_phase(40, 60, 50);
        // Port 0 stalled long enough to fill its FIFO
        run_phase(30, 0, 100);
        rx_block_lock[1] <= 1'b0;
        run_phase(8, 100, 100);
        rx_block_lock[1] <= 1'b1;
        run_phase(20, 80, 100);
        tx_ready[0] <= 1'b1;
        tx_ready[1] <= 1'b1;
        for (int i = 0; i < 500 && exp_q[0].size() + exp_q[1].size() > 0; i++) begin
            @(posedge clk_125mhz);
        end
        repeat (4) @(posedge clk_125mhz);
        for (int p = 0; p < 2; p++) begin
            if (exp_q[p].size() > 0) begin
                $display("Port %0d never sent %0d expected beats", p, exp_q[p].size());
                err_cnt++;
            end
        end
        $display("Errors: %0d, tx beats checked: %0d", err_cnt, checked);
        if (err_cnt == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired before the run finished");
        $display("Errors: %0d, tx beats checked: %0d", err_cnt, checked);
        $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- frame_loop_core.f
src/frame_loop_pkg.sv
src/link_status_timer.sv
src/frame_admit_fsm.sv
src/frame_fifo_mem.sv
src/frame_loop_ch.sv
src/frame_loop_core.sv
dv/frame_loop_tb.sv
